/* verilog/neuralPkg.sv */
package neuralPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Word types.
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [7:0] featureT; // Feature, hidden weight and hidden bias.
	typedef logic [7:0] activationT; // ReLU output, never negative.
	typedef logic [7:0] scoreT;
	typedef logic [4:0] featureIndexT;

	localparam int numFeatures = 30;
	localparam int numHidden = 2;

	// Index of the final word in a frame.
	localparam featureIndexT lastFeature = featureIndexT'(numFeatures - 1);

	// ~~~~~~~~~~~~~~~~~~~~
	// Hidden layer.
	// ~~~~~~~~~~~~~~~~~~~~

	// Products keep only their low byte, so all values below wrap modulo 256.
	localparam featureT hiddenWeights [numHidden][numFeatures] = '{
		'{
			8'sb11111100, // Feature 0.
			8'sb00011100,
			8'sb01000010,
			8'sb11001111,
			8'sb00000101,
			8'sb01000001,
			8'sb00011100,
			8'sb10000110,
			8'sb00011000,
			8'sb10100000,
			8'sb11101010, // Feature 10.
			8'sb00011000,
			8'sb00101000,
			8'sb00000101,
			8'sb00111100,
			8'sb11000100,
			8'sb00111110,
			8'sb00011011,
			8'sb11111010,
			8'sb00000010,
			8'sb11101110, // Feature 20.
			8'sb00111111,
			8'sb11000110,
			8'sb11100010,
			8'sb11101111,
			8'sb00011110,
			8'sb00100111,
			8'sb11111111,
			8'sb00010010,
			8'sb00000110
		},
		'{
			8'sb00010011, // Feature 0.
			8'sb11110101,
			8'sb00100110,
			8'sb11011001,
			8'sb00001110,
			8'sb10111010,
			8'sb00110001,
			8'sb11100111,
			8'sb00000111,
			8'sb01010010,
			8'sb11110001, // Feature 10.
			8'sb00101101,
			8'sb10011100,
			8'sb00011001,
			8'sb11101000,
			8'sb00000011,
			8'sb01001011,
			8'sb11010110,
			8'sb00111010,
			8'sb11111101,
			8'sb00010110, // Feature 20.
			8'sb10101001,
			8'sb00001001,
			8'sb01100100,
			8'sb11000011,
			8'sb00100001,
			8'sb11101101,
			8'sb01011000,
			8'sb11110110,
			8'sb00001011
		}
	};

	localparam featureT hiddenBias [numHidden] = '{
		8'sb11111001,
		8'sb00001100
	};

	// ~~~~~~~~~~~~~~~~~~~~
	// Output layer.
	// ~~~~~~~~~~~~~~~~~~~~

	// One weight per hidden neuron, in the order of the hidden instances.
	localparam featureT outputWeights [numHidden] = '{
		8'sb00101011,
		8'sb11010011
	};

	localparam featureT outputBias = 8'sb00000100;

endpackage

/* verilog/featureBuffer.sv */
module featureBuffer (
	input logic clk,
	input logic reset,
	input logic inReq,
	input neuralPkg::featureT inData,
	output logic inAck,
	output neuralPkg::featureT featureWord,
	output neuralPkg::featureIndexT featureIndex,
	output logic featureValid,
	output logic featureLast,
	input logic frameDone
);

	typedef enum logic [1:0]
	{
		receive,
		sweep,
		waitResult
	} bufferStateT;

	bufferStateT state;
	neuralPkg::featureT frame [neuralPkg::numFeatures];
	neuralPkg::featureIndexT wordCount;
	logic takeWord;

	// A word is taken only in receive, and only once per four-phase cycle.
	assign takeWord = (state == receive) && inReq && !inAck;

	assign featureWord = frame[featureIndex];
	assign featureLast = featureValid && (featureIndex == neuralPkg::lastFeature);

	// ~~~~~~~~~~~~~~~~~~~~
	// Frame storage.
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (takeWord)
			frame[wordCount] <= inData;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Handshake and sweep control.
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= receive;
			inAck <= 1'b0;
			wordCount <= '0;
			featureIndex <= '0;
			featureValid <= 1'b0;
		end
		else
		begin
			// The last acknowledge of a frame may still fall during the sweep.
			if (takeWord)
				inAck <= 1'b1;
			else if (!inReq)
				inAck <= 1'b0;

			case (state)
				receive:
				begin
					if (takeWord)
					begin
						if (wordCount == neuralPkg::lastFeature)
						begin
							wordCount <= '0;
							featureIndex <= '0;
							featureValid <= 1'b1; // Index 0 goes out next cycle.
							state <= sweep;
						end
						else
							wordCount <= wordCount + 1'b1;
					end
				end
				sweep:
				begin
					if (featureLast)
					begin
						featureValid <= 1'b0;
						featureIndex <= '0;
						state <= waitResult;
					end
					else
						featureIndex <= featureIndex + 1'b1;
				end
				waitResult:
				begin
					if (frameDone)
						state <= receive;
				end
				default:
					state <= receive;
			endcase
		end
	end

endmodule

/* verilog/hiddenNeuron.sv */
module hiddenNeuron #(
	parameter int neuronIndex = 0
) (
	input logic clk,
	input logic reset,
	input neuralPkg::featureT featureWord,
	input neuralPkg::featureIndexT featureIndex,
	input logic featureValid,
	input logic featureLast,
	output neuralPkg::activationT activation,
	output logic hiddenValid
);

	neuralPkg::featureT weight;
	neuralPkg::featureT product;
	neuralPkg::featureT baseSum;
	neuralPkg::featureT partialSum;
	neuralPkg::featureT nextSum;
	logic finish;

	assign weight = neuralPkg::hiddenWeights[neuronIndex][featureIndex];

	// Only the low byte of the product survives, as in the parallel neuron.
	assign product = featureWord * weight;

	// The bias seeds the sum at index 0, so no clear is needed between frames.
	assign baseSum = (featureIndex == '0) ? neuralPkg::hiddenBias[neuronIndex] : partialSum;
	assign nextSum = baseSum + product; // Wraps modulo 256.

	assign finish = featureValid && featureLast;

	always_ff @(posedge clk)
	begin
		if (featureValid)
			partialSum <= nextSum;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// ReLU and result.
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
			hiddenValid <= 1'b0;
		end
		else
		begin
			hiddenValid <= finish;
			if (finish)
			begin
				if (nextSum[7])
					activation <= '0; // Negative sums clamp to zero.
				else
					activation <= neuralPkg::activationT'(nextSum);
			end
		end
	end

endmodule

/* verilog/outputNeuron.sv */
module outputNeuron (
	input logic clk,
	input logic reset,
	input neuralPkg::activationT hiddenA,
	input logic validA,
	input neuralPkg::activationT hiddenB,
	input logic validB,
	output logic resReq,
	output neuralPkg::scoreT resScore,
	input logic resAck,
	output logic frameDone
);

	typedef enum logic [1:0]
	{
		idle,
		holdRequest,
		waitRelease
	} resultStateT;

	resultStateT state;
	neuralPkg::activationT hiddenAReg;
	neuralPkg::activationT hiddenBReg;
	logic heldA;
	logic heldB;
	neuralPkg::featureT productA;
	neuralPkg::featureT productB;
	neuralPkg::featureT outputSum;

	// Activations are at most 127, so the signed view of them is exact.
	assign productA = $signed(hiddenAReg) * neuralPkg::outputWeights[0];
	assign productB = $signed(hiddenBReg) * neuralPkg::outputWeights[1];
	assign outputSum = productA + productB + neuralPkg::outputBias;

	always_ff @(posedge clk)
	begin
		if (validA)
			hiddenAReg <= hiddenA;
		if (validB)
			hiddenBReg <= hiddenB;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			heldA <= 1'b0;
			heldB <= 1'b0;
			resReq <= 1'b0;
			resScore <= '0;
			frameDone <= 1'b0;
		end
		else
		begin
			frameDone <= 1'b0;
			if (validA)
				heldA <= 1'b1;
			if (validB)
				heldB <= 1'b1;

			case (state)
				idle:
				begin
					if (heldA && heldB)
					begin
						resScore <= outputSum[7] ? '0 : neuralPkg::scoreT'(outputSum);
						resReq <= 1'b1;
						heldA <= 1'b0;
						heldB <= 1'b0;
						state <= holdRequest;
					end
				end
				holdRequest:
				begin
					if (resAck)
					begin
						resReq <= 1'b0;
						state <= waitRelease;
					end
				end
				waitRelease:
				begin
					// The sink has let go, so the buffer may take the next frame.
					if (!resAck)
					begin
						frameDone <= 1'b1;
						state <= idle;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

endmodule

/* verilog/neuralCore.sv */
module neuralCore (
	input logic clk,
	input logic reset,
	input logic inReq,
	input neuralPkg::featureT inData,
	output logic inAck,
	output logic resReq,
	output neuralPkg::scoreT resScore,
	input logic resAck
);

	neuralPkg::featureT featureWord;
	neuralPkg::featureIndexT featureIndex;
	logic featureValid;
	logic featureLast;
	neuralPkg::activationT activationA;
	neuralPkg::activationT activationB;
	logic validA;
	logic validB;
	logic frameDone;

	featureBuffer buffer (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.featureWord(featureWord),
		.featureIndex(featureIndex),
		.featureValid(featureValid),
		.featureLast(featureLast),
		.frameDone(frameDone)
	);

	// Both hidden neurons see the same sweep and finish in the same cycle.
	hiddenNeuron #(.neuronIndex(0)) hiddenZero (
		.clk(clk),
		.reset(reset),
		.featureWord(featureWord),
		.featureIndex(featureIndex),
		.featureValid(featureValid),
		.featureLast(featureLast),
		.activation(activationA),
		.hiddenValid(validA)
	);

	hiddenNeuron #(.neuronIndex(1)) hiddenOne (
		.clk(clk),
		.reset(reset),
		.featureWord(featureWord),
		.featureIndex(featureIndex),
		.featureValid(featureValid),
		.featureLast(featureLast),
		.activation(activationB),
		.hiddenValid(validB)
	);

	outputNeuron scorer (
		.clk(clk),
		.reset(reset),
		.hiddenA(activationA),
		.validA(validA),
		.hiddenB(activationB),
		.validB(validB),
		.resReq(resReq),
		.resScore(resScore),
		.resAck(resAck),
		.frameDone(frameDone)
	);

endmodule

/* tests/neuralModel.svh */
`ifndef NEURAL_MODEL_SVH
`define NEURAL_MODEL_SVH

typedef neuralPkg::featureT frameT [neuralPkg::numFeatures];

// Full signed product, of which only the low byte is kept.
function automatic neuralPkg::featureT truncatedProduct(
	input neuralPkg::featureT a,
	input neuralPkg::featureT b
);
	int full;
	full = int'(a) * int'(b);
	return neuralPkg::featureT'(full[7:0]);
endfunction

function automatic neuralPkg::featureT wrappingSum(
	input neuralPkg::featureT a,
	input neuralPkg::featureT b
);
	int full;
	full = int'(a) + int'(b);
	return neuralPkg::featureT'(full[7:0]); // Modulo 256.
endfunction

function automatic neuralPkg::featureT relu(input neuralPkg::featureT x);
	if (x < 0)
		return '0;
	else
		return x;
endfunction

function automatic neuralPkg::featureT hiddenModel(input frameT frame, input int neuron);
	neuralPkg::featureT sum;
	int i;
	sum = neuralPkg::hiddenBias[neuron];
	for (i = 0; i < neuralPkg::numFeatures; i++)
		sum = wrappingSum(sum,
			truncatedProduct(frame[i], neuralPkg::hiddenWeights[neuron][i]));
	return relu(sum);
endfunction

// Score of a whole frame through both layers.
function automatic neuralPkg::scoreT frameScore(input frameT frame);
	neuralPkg::featureT sum;
	int n;
	sum = neuralPkg::outputBias;
	for (n = 0; n < neuralPkg::numHidden; n++)
		sum = wrappingSum(sum,
			truncatedProduct(hiddenModel(frame, n), neuralPkg::outputWeights[n]));
	return neuralPkg::scoreT'(relu(sum));
endfunction

`endif

/* tests/neuralCoreTb.sv */
module neuralCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	`include "neuralModel.svh"

	localparam int numFrames = 12;
	localparam int clockPeriod = 8;
	localparam int maxSourceDelay = 3;
	localparam int maxSinkDelay = 7;
	localparam logic [31:0] seed = 32'h1f89_d79e;
	// Each word costs its pause and four handshake cycles, then the result latency follows.
	localparam int worstFrameCycles = neuralPkg::numFeatures * (maxSourceDelay + 6)
		+ 33 + 2 * maxSinkDelay + 10;

	logic clk;
	logic reset;
	logic inReq;
	neuralPkg::featureT inData;
	logic inAck;
	logic resReq;
	neuralPkg::scoreT resScore;
	logic resAck;

	logic [31:0] sourceRng;
	logic [31:0] sinkRng;
	neuralPkg::featureT frames [numFrames][neuralPkg::numFeatures];
	neuralPkg::scoreT expectedScores [numFrames];
	int ackCount;
	int resultCount;
	logic inAckLast;
	logic resReqLast;

	neuralCore dut_i (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.resReq(resReq),
		.resScore(resScore),
		.resAck(resAck)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic failRun(input string reason);
		$display("error %0d ns: %s", $time, reason);
		$display("*** FAILED ***");
		$fatal(1, "Check failed.");
	endtask

	task automatic idleCycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	// The first frames hold zeros and the extreme values, the rest are random.
	task automatic buildFrames();
		int f;
		int i;
		for (f = 0; f < numFrames; f++)
		begin
			for (i = 0; i < neuralPkg::numFeatures; i++)
			begin
				sourceRng = xorshift(sourceRng);
				case (f)
					0: frames[f][i] = 8'sd0;
					1: frames[f][i] = -8'sd128;
					2: frames[f][i] = 8'sd127;
					3: frames[f][i] = i[0] ? 8'sd127 : -8'sd128;
					default: frames[f][i] = neuralPkg::featureT'(sourceRng[7:0]);
				endcase
			end
			expectedScores[f] = frameScore(frames[f]);
		end
	endtask

	task automatic sendWord(input neuralPkg::featureT word);
		sourceRng = xorshift(sourceRng);
		idleCycles(sourceRng % (maxSourceDelay + 1));
		inData <= word;
		inReq <= 1'b1;
		do @(posedge clk); while (!inAck);
		inReq <= 1'b0;
		do @(posedge clk); while (inAck);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus.
	// ~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		int f;
		int i;
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		sourceRng = seed;
		buildFrames();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (f = 0; f < numFrames; f++)
			for (i = 0; i < neuralPkg::numFeatures; i++)
				sendWord(frames[f][i]);
		while (resultCount < numFrames || resReq || resAck)
			@(posedge clk);
		if (resultCount == numFrames)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
			failRun($sformatf("%0d results for %0d frames", resultCount, numFrames));
	end

	// Sink with random pauses, which back-pressures the result.
	initial
	begin
		resAck = 1'b0;
		sinkRng = xorshift(~seed);
		forever
		begin
			do @(posedge clk); while (!resReq);
			sinkRng = xorshift(sinkRng);
			idleCycles(sinkRng % (maxSinkDelay + 1));
			resAck <= 1'b1;
			do @(posedge clk); while (resReq);
			sinkRng = xorshift(sinkRng);
			idleCycles(sinkRng % (maxSinkDelay + 1));
			resAck <= 1'b0;
		end
	end

	initial
	begin
		repeat (8 + numFrames * worstFrameCycles) @(posedge clk);
		$display("Timeout: the frames did not finish within the expected number of cycles.");
		$display("*** FAILED ***");
		$fatal(1, "Watchdog expired.");
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk)
	begin
		inAckLast <= inAck;
		resReqLast <= resReq;
		if (reset)
		begin
			ackCount <= 0;
			resultCount <= 0;
		end
		else if (resReq && !resReqLast)
		begin
			ackCount <= 0; // A new frame starts counting.
			resultCount <= resultCount + 1;
		end
		else if (inAck && !inAckLast)
			ackCount <= ackCount + 1;
	end

	scoreMatches: assert property (@(posedge clk) disable iff (reset)
		$rose(resReq) |-> resScore == expectedScores[resultCount])
		else failRun($sformatf("score %0d, model gives %0d", $sampled(resScore),
			expectedScores[$sampled(resultCount)]));

	scoreNonNegative: assert property (@(posedge clk) disable iff (reset) !resScore[7])
		else failRun($sformatf("negative score %0d", $sampled(resScore)));

	ackFollowsReq: assert property (@(posedge clk) disable iff (reset) $rose(inAck) |-> inReq)
		else failRun("inAck rose without inReq");

	ackFallsAfterReq: assert property (@(posedge clk) disable iff (reset)
		$fell(inAck) |-> !$past(inReq))
		else failRun("inAck fell while inReq was still high");

	wordsPerFrame: assert property (@(posedge clk) disable iff (reset)
		$rose(resReq) |-> ackCount == neuralPkg::numFeatures)
		else failRun($sformatf("result after %0d words", $sampled(ackCount)));

	noExtraWord: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> ackCount < neuralPkg::numFeatures)
		else failRun("word acknowledged before the pending result was taken");

	scoreHeld: assert property (@(posedge clk) disable iff (reset)
		resReq && !resAck |=> $stable(resScore))
		else failRun("resScore changed while waiting for resAck");

	inputBlocked: assert property (@(posedge clk) disable iff (reset)
		resReq && !resAck |-> !inAck)
		else failRun("inAck high while a result was pending");

	quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !inAck && !resReq)
		else failRun("inAck or resReq high after reset");

	// Word 29 is stored one cycle before its ack shows, so this is 33 cycles from storage.
	fixedLatency: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) && ackCount == neuralPkg::numFeatures - 1 |-> ##32 $rose(resReq))
		else failRun("resReq did not rise 33 cycles after the last word");

endmodule

/* neuralCore.f */
verilog/neuralPkg.sv
verilog/featureBuffer.sv
verilog/hiddenNeuron.sv
verilog/outputNeuron.sv
verilog/neuralCore.sv
tests/neuralCoreTb.sv
+incdir+tests
